//--- lab_pkg.sv
`default_nettype none

package lab_pkg;

    // experiment chosen by sw[15:14]
    typedef enum logic [1:0] {
        mode_alu    = 2'd0,
        mode_shift  = 2'd1,
        mode_encode = 2'd2,
        mode_random = 2'd3
    } mode_t;

    // alu operation from sw[10:8]
    typedef enum logic [2:0] {
        op_add   = 3'd0,
        op_sub   = 3'd1,
        op_not   = 3'd2,
        op_and   = 3'd3,
        op_or    = 3'd4,
        op_xor   = 3'd5,
        op_less  = 3'd6,
        op_equal = 3'd7
    } alu_op_t;

    // packed so it lines up with ledr[6:4]
    typedef struct packed {
        logic carry;
        logic ovfl;
        logic zero;
    } alu_flags_t;

    // four active-low digits, bit 7 is dp, bits 6..0 are g..a
    typedef struct packed {
        logic [7:0] d3;
        logic [7:0] d2;
        logic [7:0] d1;
        logic [7:0] d0;
    } seg_bank_t;

    // all segments dark
    localparam logic [7:0] seg_blank = 8'hff;

    // only g lit
    localparam logic [7:0] seg_minus = 8'hbf;

    // generator seed, also the zero recovery value
    localparam logic [7:0] lfsr_reset_value = 8'h01;

endpackage

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu (
    input  logic [3:0]          a,
    input  logic [3:0]          b,
    input  lab_pkg::alu_op_t    op,
    output logic [3:0]          result,
    output lab_pkg::alu_flags_t flags
);
    import lab_pkg::*;

    logic       sub_sel;
    logic [3:0] b_eff;
    logic [4:0] sum;

    // subtract runs through the same adder as a + ~b + 1
    assign sub_sel = (op == op_sub);
    assign b_eff   = sub_sel ? ~b : b;
    assign sum     = {1'b0, a} + {1'b0, b_eff} + {4'b0000, sub_sel};

    always_comb begin
        result = 4'h0;
        flags  = '0;
        case (op)
            op_add, op_sub: begin
                result      = sum[3:0];
                flags.carry = sum[4];
                // addends agree in sign but the sum does not
                flags.ovfl  = (a[3] == b_eff[3]) && (sum[3] != a[3]);
            end
            op_not: begin
                result = ~a;
            end
            op_and: begin
                result = a & b;
            end
            op_or: begin
                result = a | b;
            end
            op_xor: begin
                result = a ^ b;
            end
            op_less: begin
                result = {3'b000, ($signed(a) < $signed(b))};
            end
            op_equal: begin
                result = {3'b000, (a == b)};
            end
        endcase
        flags.zero = (result == 4'h0);
    end

    // a subtract lands on zero exactly when the operands match
    always_comb begin
        if (op == op_sub) begin
            assert final (flags.zero == (a == b))
            else $error("alu zero flag wrong on subtract: a=%h b=%h flags=%b",
                        a, b, flags);
        end
    end

endmodule

`default_nettype wire

//--- barrel_shifter.sv
`default_nettype none

module barrel_shifter (
    input  logic [7:0] din,
    input  logic [2:0] shamt,
    input  logic       right,
    input  logic       arith,
    output logic [7:0] dout
);

    logic       fill;
    logic [7:0] stage1;
    logic [7:0] stage2;

    // sign fill only for arithmetic right shifts
    assign fill = right & arith & din[7];

    // shift by 1
    always_comb begin
        if (!shamt[0]) stage1 = din;
        else if (right) stage1 = {fill, din[7:1]};
        else stage1 = {din[6:0], 1'b0};
    end

    // shift by 2
    always_comb begin
        if (!shamt[1]) stage2 = stage1;
        else if (right) stage2 = {{2{fill}}, stage1[7:2]};
        else stage2 = {stage1[5:0], 2'b00};
    end

    // shift by 4
    always_comb begin
        if (!shamt[2]) dout = stage2;
        else if (right) dout = {{4{fill}}, stage2[7:4]};
        else dout = {stage2[3:0], 4'h0};
    end

endmodule

`default_nettype wire

//--- priority_encoder.sv
`default_nettype none

module priority_encoder (
    input  logic [7:0] src,
    input  logic       enable,
    output logic [2:0] index,
    output logic       valid
);

    logic found;

    // highest set bit wins
    always_comb begin
        found = 1'b0;
        index = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (enable && src[i] && !found) begin
                index = 3'(i);
                found = 1'b1;
            end
        end
    end

    // index stays 0 when nothing is found
    assign valid = found;

endmodule

`default_nettype wire

//--- lfsr_random.sv
`default_nettype none

module lfsr_random (
    input  logic       btn,
    input  logic       arst_n,
    input  logic       step,
    output logic [7:0] state
);
    import lab_pkg::*;

    logic feedback;

    // taps 4, 3, 2 and 0 feed the new msb
    assign feedback = state[4] ^ state[3] ^ state[2] ^ state[0];

    always_ff @(posedge btn or negedge arst_n) begin
        if (!arst_n) begin
            state <= lfsr_reset_value;
        end else if (step) begin
            // all zeros would lock up
            if (state == 8'h00) begin
                state <= lfsr_reset_value;
            end else begin
                state <= {feedback, state[7:1]};
            end
        end
    end

    // seeded nonzero and recovered from zero, so never stuck
    assert property (@(posedge btn) disable iff (!arst_n)
        $past(arst_n) |-> (state != 8'h00))
    else $error("lfsr state is zero");

endmodule

`default_nettype wire

//--- seg_hex_decoder.sv
`default_nettype none

module seg_hex_decoder (
    input  logic [3:0] digit,
    input  logic       blank,
    output logic [7:0] seg
);
    import lab_pkg::*;

    // active low, dp held high
    always_comb begin
        case (digit)
            4'h0: seg = 8'hc0;
            4'h1: seg = 8'hf9;
            4'h2: seg = 8'ha4;
            4'h3: seg = 8'hb0;
            4'h4: seg = 8'h99;
            4'h5: seg = 8'h92;
            4'h6: seg = 8'h82;
            4'h7: seg = 8'hf8;
            4'h8: seg = 8'h80;
            4'h9: seg = 8'h90;
            4'ha: seg = 8'h88;
            4'hb: seg = 8'h83;
            4'hc: seg = 8'hc6;
            4'hd: seg = 8'ha1;
            4'he: seg = 8'h86;
            default: seg = 8'h8e;
        endcase
        if (blank) seg = seg_blank;
    end

endmodule

`default_nettype wire

//--- lab_board.sv
`default_nettype none

module lab_board (
    input  logic        btn,
    input  logic        arst_n,
    input  logic [15:0] sw,
    output logic [15:0] ledr,
    output logic [7:0]  seg0,
    output logic [7:0]  seg1,
    output logic [7:0]  seg2,
    output logic [7:0]  seg3
);
    import lab_pkg::*;

    mode_t           mode;
    logic [3:0]      alu_result;
    alu_flags_t      alu_flags;
    logic [3:0]      alu_mag;
    logic [7:0]      shift_dout;
    logic [2:0]      enc_index;
    logic            enc_valid;
    logic [7:0]      rnd_state;
    logic [3:0][3:0] dig;
    logic [3:0]      dig_blank;
    logic [3:0][7:0] dec_seg;
    seg_bank_t       seg_bank;

    assign mode = mode_t'(sw[15:14]);

    alu u_alu (
        .a      (sw[3:0]),
        .b      (sw[7:4]),
        .op     (alu_op_t'(sw[10:8])),
        .result (alu_result),
        .flags  (alu_flags)
    );

    barrel_shifter u_shifter (
        .din   (sw[7:0]),
        .shamt (sw[13:11]),
        .right (sw[10]),
        .arith (sw[9]),
        .dout  (shift_dout)
    );

    priority_encoder u_encoder (
        .src    (sw[7:0]),
        .enable (sw[8]),
        .index  (enc_index),
        .valid  (enc_valid)
    );

    // steps only while its experiment is selected
    lfsr_random u_random (
        .btn    (btn),
        .arst_n (arst_n),
        .step   (mode == mode_random),
        .state  (rnd_state)
    );

    // -8 wraps to 4'h8, still the right magnitude
    assign alu_mag = alu_result[3] ? (4'h0 - alu_result) : alu_result;

    always_comb begin
        ledr      = 16'h0000;
        dig       = '0;
        dig_blank = 4'b1111;
        case (mode)
            mode_alu: begin
                ledr[3:0]    = alu_result;
                ledr[6:4]    = {alu_flags.carry, alu_flags.ovfl, alu_flags.zero};
                dig[0]       = alu_mag;
                dig_blank[0] = 1'b0;
            end
            mode_shift: begin
                ledr[7:0] = shift_dout;
                dig       = {sw[7:4], sw[3:0], shift_dout[7:4], shift_dout[3:0]};
                dig_blank = 4'b0000;
            end
            mode_encode: begin
                ledr[2:0]    = enc_index;
                ledr[4]      = enc_valid;
                dig[0]       = {1'b0, enc_index};
                dig_blank[0] = !enc_valid;
            end
            mode_random: begin
                ledr[7:0]      = rnd_state;
                dig[1]         = rnd_state[7:4];
                dig[0]         = rnd_state[3:0];
                dig_blank[1:0] = 2'b00;
            end
        endcase
    end

    for (genvar i = 0; i < 4; i++) begin : g_dec
        seg_hex_decoder u_dec (
            .digit (dig[i]),
            .blank (dig_blank[i]),
            .seg   (dec_seg[i])
        );
    end

    // alu sign digit bypasses its decoder
    always_comb begin
        seg_bank.d3 = dec_seg[3];
        seg_bank.d2 = dec_seg[2];
        seg_bank.d0 = dec_seg[0];
        if (mode == mode_alu) seg_bank.d1 = alu_result[3] ? seg_minus : seg_blank;
        else seg_bank.d1 = dec_seg[1];
    end

    assign seg0 = seg_bank.d0;
    assign seg1 = seg_bank.d1;
    assign seg2 = seg_bank.d2;
    assign seg3 = seg_bank.d3;

    // generator holds while another experiment is shown
    assert property (@(posedge btn) disable iff (!arst_n)
        (mode != mode_random) |=> $stable(rnd_state))
    else $error("generator stepped outside random mode: %h", rnd_state);

endmodule

`default_nettype wire

//--- tb_lab_board.sv
`default_nettype none

module tb_lab_board;
    timeunit 1ns;
    timeprecision 100ps;
    import lab_pkg::*;

    localparam int max_cycles = 2000;
    // active-low digit patterns 0..F, dp dark
    localparam logic [7:0] seg_table [16] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e
    };

    logic        btn;
    logic        arst_n;
    logic [15:0] sw;
    logic [15:0] ledr;
    logic [7:0]  seg0;
    logic [7:0]  seg1;
    logic [7:0]  seg2;
    logic [7:0]  seg3;
    logic [31:0] rng;
    logic [7:0]  rnd_model;
    int          cycle_count = 0;
    int          check_count;
    int          error_count;

    lab_board lab_board_inst (
        .btn    (btn),
        .arst_n (arst_n),
        .sw     (sw),
        .ledr   (ledr),
        .seg0   (seg0),
        .seg1   (seg1),
        .seg2   (seg2),
        .seg3   (seg3)
    );

    initial begin
        btn = 1'b0;
        forever #5 btn = ~btn;
    end

    always @(posedge btn) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= max_cycles);
        $display("timeout, run stopped after %0d cycles", cycle_count);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // new msb from taps 4, 3, 2, 0; zero recovers to 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        if (s == 8'h00) return 8'h01;
        return {s[4] ^ s[3] ^ s[2] ^ s[0], s[7:1]};
    endfunction

    // the edge steps the generator if the old switches chose random mode
    task automatic tick(input logic [15:0] sw_val);
        @(posedge btn);
        if (arst_n && sw[15:14] == mode_random) rnd_model = lfsr_next(rnd_model);
        #1;
        sw = sw_val;
        #4;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("mismatch %s: expected %h, got %h at %0t", name, expected, actual, $time);
    endtask

    task automatic check_outputs(input logic [15:0] exp_ledr, input logic [31:0] exp_segs);
        check_count++;
        if (ledr !== exp_ledr) report_mismatch("ledr", {16'h0000, exp_ledr}, {16'h0000, ledr});
        if ({seg3, seg2, seg1, seg0} !== exp_segs)
            report_mismatch("seg3..seg0", exp_segs, {seg3, seg2, seg1, seg0});
    endtask

    task automatic check_random_state();
        check_outputs({8'h00, rnd_model}, {seg_blank, seg_blank,
                      seg_table[rnd_model[7:4]], seg_table[rnd_model[3:0]]});
    endtask

    task automatic end_test(input string name, input int start_errors);
        $display("test %s finished with %0d errors", name, error_count - start_errors);
    endtask

    task automatic random_sequence();
        int start_errors;
        start_errors = error_count;
        tick({mode_random, 14'h0000});
        // fresh out of reset
        check_outputs(16'h0001, {seg_blank, seg_blank, seg_table[0], seg_table[1]});
        for (int i = 0; i < 100; i++) begin
            rng = xorshift32(rng);
            tick({mode_random, rng[13:0]});
            check_random_state();
        end
        end_test("random sequence", start_errors);
    endtask

    task automatic random_hold();
        int start_errors;
        start_errors = error_count;
        for (int i = 0; i < 4; i++) begin
            tick({mode_random, 14'h0000});
            check_random_state();
        end
        // alu edges must leave the generator alone
        for (int i = 0; i < 6; i++) begin
            rng = xorshift32(rng);
            tick({mode_alu, rng[13:0]});
        end
        tick({mode_random, 14'h0000});
        check_random_state();
        end_test("random hold", start_errors);
    endtask

    task automatic alu_ops();
        int         start_errors;
        int         value;
        logic [3:0] a;
        logic [3:0] b;
        logic [3:0] r;
        logic [3:0] mag;
        logic [4:0] sum;
        logic       carry;
        logic       ovfl;
        alu_op_t    op;
        start_errors = error_count;
        for (int i = 0; i < 200; i++) begin
            rng = xorshift32(rng);
            a = rng[3:0];
            b = rng[7:4];
            op = alu_op_t'(rng[10:8]);
            tick({mode_alu, rng[13:11], op, b, a});
            carry = 1'b0;
            ovfl = 1'b0;
            case (op)
                op_add: begin
                    sum = {1'b0, a} + {1'b0, b};
                    r = sum[3:0];
                    carry = sum[4];
                    ovfl = (a[3] == b[3]) && (r[3] != a[3]);
                end
                op_sub: begin
                    sum = {1'b0, a} + {1'b0, ~b} + 5'd1;
                    r = sum[3:0];
                    carry = sum[4];
                    ovfl = (a[3] != b[3]) && (r[3] != a[3]);
                end
                op_not: r = ~a;
                op_and: r = a & b;
                op_or: r = a | b;
                op_xor: r = a ^ b;
                op_less: r = ($signed(a) < $signed(b)) ? 4'h1 : 4'h0;
                default: r = (a == b) ? 4'h1 : 4'h0;
            endcase
            value = r[3] ? int'(r) - 16 : int'(r);
            mag = 4'(value < 0 ? -value : value);
            check_outputs({9'h000, carry, ovfl, r == 4'h0, r}, {seg_blank, seg_blank,
                          r[3] ? seg_minus : seg_blank, seg_table[mag]});
        end
        end_test("alu", start_errors);
    endtask

    task automatic shifter_ops();
        int         start_errors;
        logic [7:0] din;
        logic [7:0] dout;
        logic [2:0] shamt;
        logic       right;
        logic       arith;
        start_errors = error_count;
        for (int i = 0; i < 203; i++) begin
            rng = xorshift32(rng);
            {shamt, right, arith} = rng[13:9];
            din = rng[7:0];
            // corner cases lead the random ones
            if (i == 0) {din, shamt, right, arith} = {8'h80, 3'd7, 1'b1, 1'b1};
            else if (i == 1) {din, shamt, right, arith} = {8'h80, 3'd7, 1'b1, 1'b0};
            else if (i == 2) shamt = 3'd0;
            if (!right) dout = din << shamt;
            else if (arith) dout = $signed(din) >>> shamt;
            else dout = din >> shamt;
            tick({mode_shift, shamt, right, arith, rng[8], din});
            check_outputs({8'h00, dout}, {seg_table[din[7:4]], seg_table[din[3:0]],
                          seg_table[dout[7:4]], seg_table[dout[3:0]]});
        end
        end_test("barrel shifter", start_errors);
    endtask

    task automatic encoder_scan();
        int         start_errors;
        logic [7:0] src;
        logic [2:0] index;
        logic       valid;
        logic       enable;
        start_errors = error_count;
        for (int i = 0; i < 288; i++) begin
            rng = xorshift32(rng);
            src = (i < 256) ? 8'(i) : rng[7:0];
            enable = (i < 256);
            index = 3'd0;
            valid = 1'b0;
            for (int k = 0; k < 8; k++) begin
                if (enable && src[k]) begin
                    index = 3'(k);
                    valid = 1'b1;
                end
            end
            tick({mode_encode, rng[13:9], enable, src});
            check_outputs({11'h000, valid, 1'b0, index}, {seg_blank, seg_blank, seg_blank,
                          valid ? seg_table[index] : seg_blank});
        end
        end_test("priority encoder", start_errors);
    endtask

    initial begin
        sw = 16'h0000;
        arst_n = 1'b0;
        rng = 32'hc56d_17d8;
        rnd_model = 8'h01;
        check_count = 0;
        error_count = 0;
        repeat (16) @(posedge btn);
        #1;
        arst_n = 1'b1;
        random_sequence();
        random_hold();
        alu_ops();
        shifter_ops();
        encoder_scan();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) $display("STATUS: PASS");
        else $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
lab_pkg.sv
alu.sv
barrel_shifter.sv
priority_encoder.sv
lfsr_random.sv
seg_hex_decoder.sv
lab_board.sv
tb_lab_board.sv

//--- run.sh
#!/bin/sh
# build and run the lab board testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_lab_board \
    -o sim_lab_board > build.log 2>&1 \
    && ./obj_dir/sim_lab_board > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "STATUS: FAIL" sim.log \
    && grep -q "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
